/* design/rvCore_defs.svh */
// core-wide constants, included by the package and by design files that size ports from them
`ifndef RVCORE_DEFS_SVH
`define RVCORE_DEFS_SVH

// datapath width in bits
`define XLEN 32

`define IMEM_DEPTH 64 // instruction words in local memory

// first fetch address after reset or restart
`define RESET_PC 32'h0000_0000

`endif

/* design/rvPkg.sv */
// shared types for the rv32i core, imported by the design modules
`include "rvCore_defs.svh"

package rvPkg;

    typedef logic [`XLEN-1:0] word_t; // data word
    typedef logic [31:0] instr_t;
    typedef logic [4:0] regAddr_t; // x0..x31

    // major opcode classes
    typedef enum logic [3:0] {
        LTYPE, ITYPE, AUIPC, STYPE, RTYPE, LUI, BTYPE, JALR, JTYPE, HALT, NOP
    } opCode_t;

    typedef enum logic [1:0] {ZERO, ONE, TWO, THREE} alu_sel_t; // operand mux selects
    typedef enum logic [1:0] {ADD, PASS_S1, TYPE_I, TYPE_R} aluOp_t;

    // decoded control bundle
    typedef struct packed {
        logic     jump;
        logic     jumpReg;
        logic     branch;
        logic     memRead;
        logic     memWrite;
        logic     memtoReg;
        logic     regWrite;
        alu_sel_t aluSrc1;
        alu_sel_t aluSrc2;
        aluOp_t   aluOp;
        logic     halt; // ecall / ebreak
    } ctrl_t;

    typedef struct packed {
        logic  valid;
        logic  write; // 1 = store
        word_t addr;
        word_t wdata;
    } memReq_t;

    // apb master to slave
    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        word_t             paddr;
        word_t             pwdata;
        logic [`XLEN/8-1:0] pstrb; // word only, all ones
    } apbReq_t;

    typedef struct packed {
        logic  pready;
        word_t prdata;
        logic  pslverr; // completes the transfer, otherwise ignored
    } apbRsp_t;

    typedef enum logic [1:0] {IDLE, SETUP, ACCESS} apbState_t;
    typedef enum logic {RUN, HALTED} coreState_t;

endpackage : rvPkg

/* design/controlUnit.sv */
// main decoder, turns the major opcode into the control bundle used by the core datapath
`timescale 1ns/1ps

module controlUnit (
    input  logic [6:0]   opCode,
    input  logic         enable,
    input  logic         startProcess,
    output rvPkg::ctrl_t ctrl
);
    import rvPkg::*;

    opCode_t opClass;

    // raw opcode to class
    always_comb begin
        case (opCode)
            7'b0000011: opClass = LTYPE;
            7'b0010011: opClass = ITYPE;
            7'b0010111: opClass = AUIPC;
            7'b0100011: opClass = STYPE;
            7'b0110011: opClass = RTYPE;
            7'b0110111: opClass = LUI;
            7'b1100011: opClass = BTYPE;
            7'b1100111: opClass = JALR;
            7'b1101111: opClass = JTYPE;
            7'b1110011: opClass = HALT; // ecall, ebreak
            default:    opClass = NOP;  // fence, csr and unknowns fall through
        endcase
    end

    // class  |jmp|jReg|br|mRd|mWr|m2R|rWr|src1|src2|aluOp  |halt
    // LTYPE  | 0 | 0  |0 | 1 | 0 | 1 | 1 | 00 | 01 |ADD    | 0
    // ITYPE  | 0 | 0  |0 | 0 | 0 | 0 | 1 | 00 | 01 |TYPE_I | 0
    // AUIPC  | 0 | 0  |0 | 0 | 0 | 0 | 1 | 01 | 11 |ADD    | 0
    // STYPE  | 0 | 0  |0 | 0 | 1 | 0 | 0 | 00 | 10 |ADD    | 0
    // RTYPE  | 0 | 0  |0 | 0 | 0 | 0 | 1 | 00 | 00 |TYPE_R | 0
    // LUI    | 0 | 0  |0 | 0 | 0 | 0 | 1 | 01 | 00 |PASS_S1| 0
    // BTYPE  | 0 | 0  |1 | 0 | 0 | 0 | 0 | 00 | 00 |ADD    | 0
    // JALR   | 0 | 1  |0 | 0 | 0 | 0 | 1 | 10 | 11 |ADD    | 0
    // JTYPE  | 1 | 0  |0 | 0 | 0 | 0 | 1 | 10 | 11 |ADD    | 0
    // HALT   | 0 | 0  |0 | 0 | 0 | 0 | 0 | 00 | 00 |ADD    | 1
    always_comb begin
        ctrl = '0; // everything inactive
        ctrl.aluSrc1 = ZERO;
        ctrl.aluSrc2 = ZERO;
        ctrl.aluOp = ADD;

        if (enable && startProcess) begin
            case (opClass)
                LTYPE: begin
                    ctrl.aluSrc2 = ONE; // base + i imm
                    ctrl.memRead = 1'b1;
                    ctrl.memtoReg = 1'b1;
                    ctrl.regWrite = 1'b1;
                end
                ITYPE: begin
                    ctrl.aluSrc2 = ONE;
                    ctrl.regWrite = 1'b1;
                    ctrl.aluOp = TYPE_I;
                end
                AUIPC: begin
                    ctrl.aluSrc1 = ONE; // pc
                    ctrl.aluSrc2 = THREE; // u imm
                    ctrl.regWrite = 1'b1;
                end
                STYPE: begin
                    ctrl.aluSrc2 = TWO; // s imm
                    ctrl.memWrite = 1'b1;
                end
                RTYPE: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.aluOp = TYPE_R; // funct7 matters here
                end
                LUI: begin
                    ctrl.aluSrc1 = ONE;
                    ctrl.regWrite = 1'b1;
                    ctrl.aluOp = PASS_S1;
                end
                BTYPE: ctrl.branch = 1'b1; // compare done in alu
                JALR: begin
                    ctrl.jumpReg = 1'b1;
                    ctrl.aluSrc1 = TWO;
                    ctrl.aluSrc2 = THREE; // link = pc + 4
                    ctrl.regWrite = 1'b1;
                end
                JTYPE: begin
                    ctrl.jump = 1'b1;
                    ctrl.aluSrc1 = TWO;
                    ctrl.aluSrc2 = THREE;
                    ctrl.regWrite = 1'b1;
                end
                HALT: ctrl.halt = 1'b1;
                default: begin
                end
            endcase
        end
    end

endmodule : controlUnit

/* design/immGen.sv */
// immediate generator, extracts and sign-extends the immediate of the fetched instruction
`timescale 1ns/1ps
`include "rvCore_defs.svh"

module immGen (
    input  rvPkg::instr_t instr,
    output rvPkg::word_t  imm
);

    logic signBit;

    assign signBit = instr[31]; // all formats sign from bit 31

    // format picked from opcode[6:2]
    always_comb begin
        case (instr[6:2])
            5'b01000: begin // store
                imm = {{(`XLEN-12){signBit}}, instr[31:25], instr[11:7]};
            end
            5'b11000: begin // branch, offset in halfwords
                imm = {{(`XLEN-13){signBit}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            5'b01101, 5'b00101: begin // lui, auipc
                imm = {{(`XLEN-32){signBit}}, instr[31:12], 12'b0};
            end
            5'b11011: begin // jal
                imm = {{(`XLEN-21){signBit}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            default: begin
                // loads, op-imm, jalr, system
                imm = {{(`XLEN-12){signBit}}, instr[31:20]};
            end
        endcase
    end

endmodule : immGen

/* design/regFile.sv */
// integer register file, two async read ports and one sync write port, x0 reads zero
`timescale 1ns/1ps

module regFile (
    input  logic            clk,
    input  logic            rstN,
    input  logic            we,
    input  rvPkg::regAddr_t rs1,
    input  rvPkg::regAddr_t rs2,
    input  rvPkg::regAddr_t rd,
    input  rvPkg::word_t    wdata,
    output rvPkg::word_t    rdata1,
    output rvPkg::word_t    rdata2
);
    import rvPkg::*;

    word_t regs [32];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != '0)) begin // x0 writes dropped
            regs[rd] <= wdata;
        end
    end

    // x0 never written so stays zero
    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

endmodule : regFile

/* design/alu.sv */
// operand selection, integer ALU and branch condition for the single-cycle datapath
`timescale 1ns/1ps

module alu (
    input  rvPkg::ctrl_t ctrl,
    input  rvPkg::word_t pc,
    input  rvPkg::word_t rs1Data,
    input  rvPkg::word_t rs2Data,
    input  rvPkg::word_t imm,
    input  logic [2:0]   funct3,
    input  logic         funct7b5,
    output rvPkg::word_t result,
    output logic         branchTaken
);
    import rvPkg::*;

    word_t opA;
    word_t opB;
    logic [4:0] shamt;
    logic subOp;
    logic cond;

    always_comb begin
        // ONE and TWO both select pc
        opA = (ctrl.aluSrc1 == ZERO) ? rs1Data : pc;
        case (ctrl.aluSrc2)
            ZERO:  opB = rs2Data;
            THREE: opB = (ctrl.jump || ctrl.jumpReg) ? word_t'(4) : imm; // link or auipc
            default: opB = imm; // i or s imm, already formatted
        endcase
    end

    assign shamt = opB[4:0];
    assign subOp = (ctrl.aluOp == TYPE_R) && funct7b5; // addi never subtracts

    always_comb begin
        case (ctrl.aluOp)
            ADD:     result = opA + opB;
            PASS_S1: result = imm; // lui, zero base + u imm
            default: begin
                case (funct3)
                    3'b000: result = subOp ? (opA - opB) : (opA + opB);
                    3'b001: result = opA << shamt;
                    3'b010: result = word_t'($signed(opA) < $signed(opB));
                    3'b011: result = word_t'(opA < opB);
                    3'b100: result = opA ^ opB;
                    3'b101: begin
                        // srai keeps bit 30 in the immediate
                        result = funct7b5 ? word_t'($signed(opA) >>> shamt) : (opA >> shamt);
                    end
                    3'b110: result = opA | opB;
                    default: result = opA & opB;
                endcase
            end
        endcase
    end

    // compare raw registers
    always_comb begin
        case (funct3)
            3'b000:  cond = (rs1Data == rs2Data);
            3'b001:  cond = (rs1Data != rs2Data);
            3'b100:  cond = ($signed(rs1Data) < $signed(rs2Data));
            3'b101:  cond = ($signed(rs1Data) >= $signed(rs2Data));
            3'b110:  cond = (rs1Data < rs2Data);
            3'b111:  cond = (rs1Data >= rs2Data);
            default: cond = 1'b0; // reserved encodings
        endcase
        branchTaken = ctrl.branch && cond;
    end

endmodule : alu

/* design/apbMaster.sv */
// APB master for word loads and stores, one setup cycle then access until pready
`timescale 1ns/1ps

module apbMaster (
    input  logic           clk,
    input  logic           rstN,
    input  rvPkg::memReq_t req,
    output logic           done,
    output rvPkg::word_t   rdata,
    output rvPkg::apbReq_t apbReq,
    input  rvPkg::apbRsp_t apbRsp
);
    import rvPkg::*;

    apbState_t state;
    logic pwriteQ;
    word_t paddrQ;
    word_t pwdataQ;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:   if (req.valid) state <= SETUP;
                SETUP:  state <= ACCESS; // always exactly one cycle
                ACCESS: if (apbRsp.pready) state <= IDLE; // wait states stretch here
                default: state <= IDLE;
            endcase
        end
    end

    // request latched on the way into setup
    always_ff @(posedge clk) begin
        if ((state == IDLE) && req.valid) begin
            pwriteQ <= req.write;
            paddrQ <= req.addr;
            pwdataQ <= req.wdata;
        end
    end

    always_comb begin
        apbReq.psel = (state != IDLE);
        apbReq.penable = (state == ACCESS);
        apbReq.pwrite = pwriteQ;
        apbReq.paddr = paddrQ;
        apbReq.pwdata = pwdataQ;
        apbReq.pstrb = '1; // word accesses only
    end

    assign done = (state == ACCESS) && apbRsp.pready; // pslverr still completes
    assign rdata = apbRsp.prdata; // sampled by the core on the done edge

endmodule : apbMaster

/* design/rvCore.sv */
// rv32i core top, holds pc, instruction memory and halt control, load program while idle then run
`timescale 1ns/1ps
`include "rvCore_defs.svh"

module rvCore (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          enable,
    input  logic                          startProcess,
    output logic                          endProcess,
    input  logic                          progWe,
    input  logic [$clog2(`IMEM_DEPTH)-1:0] progAddr, // word index
    input  rvPkg::instr_t                 progData,
    output rvPkg::apbReq_t                apbReq,
    input  rvPkg::apbRsp_t                apbRsp
);
    import rvPkg::*;

    localparam int IMEM_AW = $clog2(`IMEM_DEPTH);

    coreState_t state;
    instr_t imem [`IMEM_DEPTH];
    instr_t instr;
    ctrl_t ctrl;
    memReq_t memReq;
    word_t pc, pcNext, pcPlus4;
    word_t imm, rs1Data, rs2Data, aluResult;
    word_t memRdata, heldRdata, loadData, wbData;
    logic branchTaken, memDone, memDoneHeld;
    logic memAccess, memComplete, advance, runOk;

    always_ff @(posedge clk) begin
        if (progWe && !startProcess) begin // no writes while running
            imem[progAddr] <= progData;
        end
    end

    assign instr = imem[pc[IMEM_AW+1:2]];
    assign runOk = enable && startProcess && (state == RUN);

    controlUnit controlUnitInst (
        .opCode(instr[6:0]),
        .enable(enable && (state == RUN)), // halted core decodes nothing
        .startProcess(startProcess),
        .ctrl(ctrl)
    );

    immGen immGenInst (.instr(instr), .imm(imm));

    regFile regFileInst (
        .clk(clk), .rstN(rstN), .we(ctrl.regWrite && advance),
        .rs1(instr[19:15]), .rs2(instr[24:20]), .rd(instr[11:7]),
        .wdata(wbData), .rdata1(rs1Data), .rdata2(rs2Data)
    );

    alu aluInst (
        .ctrl(ctrl), .pc(pc), .rs1Data(rs1Data), .rs2Data(rs2Data), .imm(imm),
        .funct3(instr[14:12]), .funct7b5(instr[30]),
        .result(aluResult), .branchTaken(branchTaken)
    );

    // load or store, stall until done
    assign memAccess = ctrl.memRead || ctrl.memWrite;
    assign memComplete = memDone || memDoneHeld;
    assign advance = !memAccess || memComplete;

    always_comb begin
        memReq.valid = memAccess && !memDoneHeld; // no reissue of a finished transfer
        memReq.write = ctrl.memWrite;
        memReq.addr = aluResult; // rs1 + offset
        memReq.wdata = rs2Data;
    end

    apbMaster apbMasterInst (
        .clk(clk), .rstN(rstN), .req(memReq), .done(memDone), .rdata(memRdata),
        .apbReq(apbReq), .apbRsp(apbRsp)
    );

    // a transfer finishing while enable is low retires once enable returns
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            memDoneHeld <= 1'b0;
        end else if (!startProcess) begin
            memDoneHeld <= 1'b0;
        end else if (memDone && !runOk) begin
            memDoneHeld <= 1'b1;
        end else if (runOk) begin
            memDoneHeld <= 1'b0; // retired this cycle
        end
    end

    always_ff @(posedge clk) begin
        if (memDone) begin
            heldRdata <= memRdata;
        end
    end

    assign loadData = memDoneHeld ? heldRdata : memRdata;
    assign wbData = ctrl.memtoReg ? loadData : aluResult;
    assign pcPlus4 = pc + word_t'(4);

    always_comb begin
        if (ctrl.jumpReg) begin
            pcNext = (rs1Data + imm) & ~word_t'(1); // jalr clears bit 0
        end else if (ctrl.jump || branchTaken) begin
            pcNext = pc + imm;
        end else begin
            pcNext = pcPlus4;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= `RESET_PC;
        end else if (!startProcess) begin
            pc <= `RESET_PC; // next run starts from the top
        end else if (runOk && advance && !ctrl.halt) begin
            pc <= pcNext;
        end
    end

    // halt fsm
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= RUN;
        end else begin
            case (state)
                RUN:     if (ctrl.halt) state <= HALTED;
                HALTED:  if (!startProcess) state <= RUN;
                default: state <= RUN;
            endcase
        end
    end

    assign endProcess = (state == HALTED);

endmodule : rvCore

/* sim/rvCoreTb.sv */
// simulation top that loads the pattern file program into the rv32i core and checks its APB stores
`timescale 1ns/1ps
`include "rvCore_defs.svh"

module rvCoreTb;
    import rvPkg::*;

    localparam int IMEM_AW = $clog2(`IMEM_DEPTH);
    localparam int PRELOAD_BASE = 'h40; // preload section in the pattern image
    localparam int STORE_BASE = 'h60; // expected store section
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int QUIET_CYCLES = 30; // bus must stay idle this long after halt

    logic clk = 1'b0;
    logic rstN;
    logic enable;
    logic startProcess;
    logic endProcess;
    logic progWe;
    logic [IMEM_AW-1:0] progAddr;
    instr_t progData;
    apbReq_t apbReq;
    apbRsp_t apbRsp = '0;

    logic [31:0] patterns [128];
    logic [31:0] mem [logic [31:0]]; // sparse memory behind the APB port
    int expStores = 0;
    int storeIdx = 0;
    int waitLeft = 0; // wait states left in the current access
    logic prevPsel = 1'b0;
    logic enAtEdge = 1'b0;
    int checkCount = 0;
    int mismatchCount = 0;
    int otherErrors = 0;

    always #20 clk = ~clk; // 40 ns period

    rvCore rvCore_inst (
        .clk(clk), .rstN(rstN), .enable(enable), .startProcess(startProcess),
        .endProcess(endProcess), .progWe(progWe), .progAddr(progAddr),
        .progData(progData), .apbReq(apbReq), .apbRsp(apbRsp)
    );

    task automatic checkEq(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
        checkCount++;
        if (actual !== expected) begin
            mismatchCount++;
            $display("mismatch at %0d ns: %s, got %h, expected %h",
                     $time, what, actual, expected);
        end
    endtask

    // endProcess to a level within limit cycles
    task automatic waitEndProcess(input logic level, input int limit);
        int cycles;
        cycles = 0;
        while (endProcess !== level && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (endProcess !== level) begin
            $display("timeout: endProcess did not go %0s within %0d cycles",
                     level ? "high" : "low", limit);
            otherErrors++;
        end
    endtask

    // last access cycle checks a store against the next record or returns load data
    task automatic serveAccess();
        if (apbReq.pwrite) begin
            if (storeIdx >= expStores) begin
                $display("error at %0d ns: store to %h beyond the %0d expected stores",
                         $time, apbReq.paddr, expStores);
                otherErrors++;
            end else begin
                checkEq(apbReq.paddr, patterns[STORE_BASE + 1 + 2 * storeIdx],
                        $sformatf("store %0d address", storeIdx));
                checkEq(apbReq.pwdata, patterns[STORE_BASE + 2 + 2 * storeIdx],
                        $sformatf("store %0d data", storeIdx));
            end
            storeIdx++;
            mem[apbReq.paddr] = apbReq.pwdata;
        end else begin
            // unloaded words fold in the whole address
            apbRsp.prdata = mem.exists(apbReq.paddr) ? mem[apbReq.paddr]
                                                     : (apbReq.paddr ^ 32'h5A5A_5A5A);
        end
    endtask

    always @(posedge clk) begin
        enAtEdge <= enable; // enable seen by the edge that may start a transfer
    end

    // apb slave with 0 to 3 random wait states
    always @(negedge clk) begin
        if (apbRsp.pready) begin // transfer completed on the last rising edge
            checkEq(32'(apbReq.psel), 32'd0, "psel after a completed transfer");
        end
        apbRsp.pready = 1'b0;
        if (apbReq.penable) begin
            checkEq(32'(apbReq.psel), 32'd1, "penable without psel");
            checkEq(32'(prevPsel), 32'd1, "access phase without setup");
            checkEq(32'(apbReq.pstrb), 32'hF, "pstrb on a word access");
            if (waitLeft > 0) begin
                waitLeft--;
            end else begin
                apbRsp.pready = 1'b1; // completes on the next rising edge
                serveAccess();
            end
        end else if (apbReq.psel) begin // setup cycle
            if (!enAtEdge) begin
                $display("error at %0d ns: APB transfer started while enable was low",
                         $time);
                otherErrors++;
            end
            waitLeft = int'($urandom % 4);
        end
        prevPsel = apbReq.psel;
    end

    initial begin
        int preloadCount;
        int pauseAt;
        int pauseLen;
        rstN = 1'b0;
        enable = 1'b0;
        startProcess = 1'b0;
        progWe = 1'b0;
        progAddr = '0;
        progData = '0;
        void'($urandom(25573));
        foreach (patterns[i]) begin
            patterns[i] = '0; // unused program words decode as nop
        end
        $readmemh("sim/programPatterns.txt", patterns);

        repeat (5) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        checkEq(32'(endProcess), 32'd0, "endProcess after reset");
        checkEq(32'(apbReq.psel), 32'd0, "psel after reset");
        checkEq(32'(apbReq.penable), 32'd0, "penable after reset");

        // program port while the core is idle
        for (int i = 0; i < `IMEM_DEPTH; i++) begin
            progWe = 1'b1;
            progAddr = IMEM_AW'(i);
            progData = patterns[i];
            @(negedge clk);
        end
        progWe = 1'b0;

        preloadCount = int'(patterns[PRELOAD_BASE]);
        for (int k = 0; k < preloadCount; k++) begin
            mem[patterns[PRELOAD_BASE + 1 + 2 * k]] = patterns[PRELOAD_BASE + 2 + 2 * k];
        end
        expStores = int'(patterns[STORE_BASE]);

        enable = 1'b1;
        startProcess = 1'b1;

        // freeze the core once mid-run
        pauseAt = 8 + int'($urandom % 20);
        pauseLen = 1 + int'($urandom % 8);
        repeat (pauseAt) @(negedge clk);
        enable = 1'b0;
        repeat (pauseLen) @(negedge clk);
        enable = 1'b1;

        waitEndProcess(1'b1, TIMEOUT_CYCLES);
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            checkEq(32'(apbReq.psel), 32'd0, "psel after halt");
            checkEq(32'(endProcess), 32'd1, "endProcess while halted");
        end
        checkEq(32'(storeIdx), 32'(expStores), "number of stores");

        startProcess = 1'b0; // releases the halt
        waitEndProcess(1'b0, 4);

        $display("%0d checks, %0d mismatches, %0d other errors",
                 checkCount, mismatchCount, otherErrors);
        if (mismatchCount == 0 && otherErrors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule : rvCoreTb

/* sim/programPatterns.txt */
// @00 program words from address 0, @40 preload count then address data pairs,
// @60 expected store count then address data pairs in issue order
@00
20000513 FF900093 00500113 401101B3 // x10 = 0x200, x1 = -7, x2 = 5, sub x3 = x2 - x1
00352023 0020A233 0020B2B3 00452223 // sw x3, slt x4, sltu x5, sw x4
00552423 4020D313 0F034393 00311413 // sw x5, srai x6, xori x7, slli x8
0083E4B3 00952623 10002603 10402683 // or x9, sw x9, lw x12, lw x13
00D60733 00E52823 00300813 00178793 // add x14, sw x14, x16 = 3, x15 += 1
FF079EE3 00F52A23 00C000EF 00000093 // bne back, sw x15, jal x1 to 0x64, skipped
00000093 00152C23 01908967 00000913 // skipped, sw x1, jalr x18 to 0x74, skipped
00000913 01252E23 ABCDE9B7 00001A17 // skipped, sw x18, lui x19, auipc x20
03352023 03452223 00000073          // sw x19, sw x20, ecall
@40
00000002
00000100 12345678
00000104 0FEDCBA8
@60
0000000A
00000200 0000000C // 5 - (-7)
00000204 00000001 // -7 < 5 signed
00000208 00000000 // unsigned compare fails
0000020C FFFFFF2E // ((-7 >>> 2) ^ 0xF0) | (5 << 3)
00000210 22222220 // sum of the two loaded words
00000214 00000003 // loop counter
00000218 0000005C // jal link
0000021C 0000006C // jalr link
00000220 ABCDE000 // lui
00000224 0000107C // auipc at 0x7C

/* project.f */
+incdir+design
design/rvPkg.sv
design/controlUnit.sv
design/immGen.sv
design/regFile.sv
design/alu.sv
design/apbMaster.sv
design/rvCore.sv
sim/rvCoreTb.sv

/* run.sh */
#!/bin/sh
# build and run the rv32i core testbench with Verilator, exit status follows the result
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module rvCoreTb -f project.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/VrvCoreTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST RESULT: PASS" "$LOG"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see $LOG"
exit 1
